/* source/ecc_pkg.sv */
package ecc_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // widths and words.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int REG_SPACE_BIT = 12; // set selects the registers.

    typedef logic [17:0]              data_t;
    typedef logic [5:0]               parity_t;
    typedef logic [12:0]              addr_t;
    typedef logic [31:0]              word_t;
    typedef logic [1:0]               resp_t;
    typedef logic [15:0]              count_t;
    typedef logic [REG_SPACE_BIT-1:0] reg_off_t;

    typedef struct packed {
        parity_t parity;
        data_t   data;
    } codeword_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // axi4-lite channels.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        addr_t awaddr;
        logic  awvalid;
    } axil_aw_t;

    typedef struct packed {
        word_t      wdata;
        logic [3:0] wstrb;
        logic       wvalid;
    } axil_w_t;

    typedef struct packed {
        addr_t araddr;
        logic  arvalid;
    } axil_ar_t;

    typedef struct packed {
        resp_t bresp;
        logic  bvalid;
    } axil_b_t;

    typedef struct packed {
        word_t rdata;
        resp_t rresp;
        logic  rvalid;
    } axil_r_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    localparam reg_off_t CTRL_OFFSET  = 12'h000; // bit 0 is bypass.
    localparam reg_off_t FLIP_OFFSET  = 12'h004;
    localparam reg_off_t COUNT_OFFSET = 12'h008; // read only.

    // every data bit sits in an odd number of checks, so double errors give even weight.
    function automatic parity_t ecc_check_bits(data_t d);
        parity_t p;
        p[0] = d[0] ^ d[1] ^ d[3] ^ d[4] ^ d[6] ^ d[8] ^ d[10] ^ d[11] ^ d[13] ^ d[15] ^ d[17];
        p[1] = d[0] ^ d[2] ^ d[3] ^ d[5] ^ d[6] ^ d[9] ^ d[10] ^ d[12] ^ d[13] ^ d[16] ^ d[17];
        p[2] = d[1] ^ d[2] ^ d[3] ^ d[7] ^ d[8] ^ d[9] ^ d[10] ^ d[14] ^ d[15] ^ d[16] ^ d[17];
        p[3] = d[4] ^ d[5] ^ d[6] ^ d[7] ^ d[8] ^ d[9] ^ d[10];
        p[4] = d[11] ^ d[12] ^ d[13] ^ d[14] ^ d[15] ^ d[16] ^ d[17];
        p[5] = d[0] ^ d[1] ^ d[2] ^ d[4] ^ d[5] ^ d[7] ^ d[10] ^ d[11] ^ d[12] ^ d[14] ^ d[17];
        return p;
    endfunction

endpackage

/* source/ecc_secded_18.sv */
`timescale 1ns/1ps

module ecc_secded_18 (
    input  ecc_pkg::codeword_t stored,
    input  logic               bypass,
    output ecc_pkg::data_t     data,
    output ecc_pkg::data_t     mask,
    output logic               sbit_err,
    output logic               dbit_err
);
    import ecc_pkg::*;

    parity_t syndrome;
    data_t   fix;    // one-hot flip from the table.
    logic    single;
    logic    double;

    assign syndrome = stored.parity ^ ecc_check_bits(stored.data);

    // one column per data bit.
    always_comb begin
        fix    = '0;
        double = 1'b0;
        case (syndrome)
            6'b100011: fix[0]  = 1'b1;
            6'b100101: fix[1]  = 1'b1;
            6'b100110: fix[2]  = 1'b1;
            6'b000111: fix[3]  = 1'b1;
            6'b101001: fix[4]  = 1'b1;
            6'b101010: fix[5]  = 1'b1;
            6'b001011: fix[6]  = 1'b1;
            6'b101100: fix[7]  = 1'b1;
            6'b001101: fix[8]  = 1'b1;
            6'b001110: fix[9]  = 1'b1;
            6'b101111: fix[10] = 1'b1;
            6'b110001: fix[11] = 1'b1;
            6'b110010: fix[12] = 1'b1;
            6'b010011: fix[13] = 1'b1;
            6'b110100: fix[14] = 1'b1;
            6'b010101: fix[15] = 1'b1;
            6'b010110: fix[16] = 1'b1;
            6'b110111: fix[17] = 1'b1;
            // clean word, or a flipped check bit.
            6'b000000, 6'b000001, 6'b000010, 6'b000100,
            6'b001000, 6'b010000, 6'b100000: fix = '0;
            default: double = 1'b1;
        endcase
    end

    assign single = (|syndrome) & !double;

    assign mask     = bypass ? '0 : fix;
    assign data     = stored.data ^ mask; // raw on a double error.
    assign sbit_err = !bypass & single;
    assign dbit_err = !bypass & double;

endmodule

/* source/ecc_axil_write.sv */
`timescale 1ns/1ps

module ecc_axil_write #(
    parameter int DEPTH = 64
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  ecc_pkg::axil_aw_t        aw,
    input  ecc_pkg::axil_w_t         w,
    output logic                     awready,
    output logic                     wready,
    output ecc_pkg::axil_b_t         b,
    input  logic                     bready,
    output logic                     wr_en,
    output logic [$clog2(DEPTH)-1:0] wr_index,
    output ecc_pkg::codeword_t       wr_word,
    output logic                     bypass,
    output ecc_pkg::codeword_t       flip
);
    import ecc_pkg::*;

    localparam int IDX_W = $clog2(DEPTH);

    logic      accept;
    logic      to_regs;
    logic      bad_reg;
    reg_off_t  offset;
    data_t     data_in;
    codeword_t clean;

    assign awready = !b.bvalid;
    assign wready  = !b.bvalid;
    assign accept  = aw.awvalid & w.wvalid & awready; // both channels on one edge.
    assign to_regs = aw.awaddr[REG_SPACE_BIT];
    assign offset  = aw.awaddr[REG_SPACE_BIT-1:0];
    assign bad_reg = to_regs && offset != CTRL_OFFSET && offset != FLIP_OFFSET;
    assign data_in = w.wdata[$bits(data_t)-1:0];

    assign clean.data   = data_in;
    assign clean.parity = ecc_check_bits(data_in);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // store port.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign wr_en    = accept & !to_regs;
    assign wr_index = aw.awaddr[IDX_W+1:2];
    assign wr_word  = clean ^ flip; // injected errors land here.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bypass <= 1'b0;
            flip   <= '0;
        end else if (accept) begin
            if (!to_regs) begin
                flip <= '0; // mask is spent on one write.
            end else if (offset == CTRL_OFFSET) begin
                bypass <= w.wdata[0];
            end else if (offset == FLIP_OFFSET) begin
                flip <= w.wdata[$bits(codeword_t)-1:0];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            b.bvalid <= 1'b0;
            b.bresp  <= RESP_OKAY;
        end else if (accept) begin
            b.bvalid <= 1'b1;
            b.bresp  <= bad_reg ? RESP_SLVERR : RESP_OKAY;
        end else if (bready) begin
            b.bvalid <= 1'b0;
        end
    end

    // a response is held until the master takes it.
    assert property (@(posedge clk) disable iff (!arst_n)
        b.bvalid && !bready |=> b.bvalid && $stable(b.bresp));

endmodule

/* source/ecc_axil_read.sv */
`timescale 1ns/1ps

module ecc_axil_read #(
    parameter int DEPTH = 64
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  ecc_pkg::axil_ar_t        ar,
    output logic                     arready,
    output ecc_pkg::axil_r_t         r,
    input  logic                     rready,
    input  logic                     bypass,
    input  ecc_pkg::codeword_t       flip,
    output logic                     rd_en,
    output logic [$clog2(DEPTH)-1:0] rd_index,
    input  ecc_pkg::codeword_t       rd_word
);
    import ecc_pkg::*;

    localparam int IDX_W = $clog2(DEPTH);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR, // store read issued.
        ST_DATA, // codeword on rd_word.
        ST_RESP
    } state_t;

    state_t state;
    state_t state_next;
    addr_t  pend_addr;
    logic   pend_regs;
    count_t count;
    data_t  data;
    data_t  mask;
    logic   sbit_err;
    logic   dbit_err;
    word_t  reg_data;
    logic   reg_ok;
    word_t  rdata_q;
    resp_t  rresp_q;

    ecc_secded_18 u_secded (
        .stored   (rd_word),
        .bypass   (bypass),
        .data     (data),
        .mask     (mask),
        .sbit_err (sbit_err),
        .dbit_err (dbit_err)
    );

    assign arready   = state == ST_IDLE;
    assign pend_regs = pend_addr[REG_SPACE_BIT];
    assign rd_en     = state == ST_ADDR && !pend_regs;
    assign rd_index  = pend_addr[IDX_W+1:2];
    assign r         = '{rdata: rdata_q, rresp: rresp_q, rvalid: state == ST_RESP};

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: if (ar.arvalid) state_next = ST_ADDR;
            ST_ADDR: state_next = ST_DATA;
            ST_DATA: state_next = ST_RESP;
            ST_RESP: if (rready) state_next = ST_IDLE;
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) state <= ST_IDLE;
        else         state <= state_next;
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && ar.arvalid) pend_addr <= ar.araddr;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // register file view.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        reg_data = '0;
        reg_ok   = 1'b1;
        case (pend_addr[REG_SPACE_BIT-1:0])
            CTRL_OFFSET:  reg_data[0] = bypass;
            FLIP_OFFSET:  reg_data[$bits(codeword_t)-1:0] = flip;
            COUNT_OFFSET: reg_data[$bits(count_t)-1:0] = count;
            default:      reg_ok = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (state == ST_DATA) begin
            if (pend_regs) begin
                rdata_q <= reg_data;
                rresp_q <= reg_ok ? RESP_OKAY : RESP_SLVERR;
            end else begin
                rdata_q <= {6'b0, dbit_err, sbit_err, rd_word.parity, data};
                rresp_q <= dbit_err ? RESP_SLVERR : RESP_OKAY;
            end
        end
    end

    // counts data-bit fixes only, sticks at full scale.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else if (state == ST_DATA && !pend_regs && (|mask) && count != '1) begin
            count <= count + 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        r.rvalid && !rready |=> r.rvalid && $stable(r.rdata));

endmodule

/* source/ecc_store.sv */
`timescale 1ns/1ps

module ecc_store #(
    parameter int DEPTH = 64
) (
    input  logic                     clk,
    input  logic                     wr_en,
    input  logic [$clog2(DEPTH)-1:0] wr_index,
    input  ecc_pkg::codeword_t       wr_word,
    input  logic                     rd_en,
    input  logic [$clog2(DEPTH)-1:0] rd_index,
    output ecc_pkg::codeword_t       rd_word
);
    import ecc_pkg::*;

    codeword_t mem [DEPTH];

    // known contents from time zero.
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always @(posedge clk) begin
        if (wr_en) mem[wr_index] <= wr_word;
    end

    always_ff @(posedge clk) begin
        if (rd_en) rd_word <= mem[rd_index]; // holds between reads.
    end

    // both paths slice the byte address, so a stray address would alias.
    assert property (@(posedge clk)
        (!wr_en || wr_index < DEPTH) && (!rd_en || rd_index < DEPTH));

endmodule

/* source/ecc_ram_top.sv */
`timescale 1ns/1ps

module ecc_ram_top #(
    parameter int DEPTH = 64
) (
    input  logic              clk,
    input  logic              arst_n,
    input  ecc_pkg::axil_aw_t aw,
    input  ecc_pkg::axil_w_t  w,
    output logic              awready,
    output logic              wready,
    output ecc_pkg::axil_b_t  b,
    input  logic              bready,
    input  ecc_pkg::axil_ar_t ar,
    output logic              arready,
    output ecc_pkg::axil_r_t  r,
    input  logic              rready
);
    import ecc_pkg::*;

    localparam int IDX_W = $clog2(DEPTH);

    logic             wr_en;
    logic [IDX_W-1:0] wr_index;
    codeword_t        wr_word;
    logic             rd_en;
    logic [IDX_W-1:0] rd_index;
    codeword_t        rd_word;
    logic             bypass;
    codeword_t        flip;

    ecc_axil_write #(.DEPTH(DEPTH)) u_write (
        .clk      (clk),
        .arst_n   (arst_n),
        .aw       (aw),
        .w        (w),
        .awready  (awready),
        .wready   (wready),
        .b        (b),
        .bready   (bready),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_word  (wr_word),
        .bypass   (bypass),
        .flip     (flip)
    );

    ecc_axil_read #(.DEPTH(DEPTH)) u_read (
        .clk      (clk),
        .arst_n   (arst_n),
        .ar       (ar),
        .arready  (arready),
        .r        (r),
        .rready   (rready),
        .bypass   (bypass),
        .flip     (flip),
        .rd_en    (rd_en),
        .rd_index (rd_index),
        .rd_word  (rd_word)
    );

    ecc_store #(.DEPTH(DEPTH)) u_store (
        .clk      (clk),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_word  (wr_word),
        .rd_en    (rd_en),
        .rd_index (rd_index),
        .rd_word  (rd_word)
    );

endmodule

/* tb/ecc_ram_checker.sv */
`timescale 1ns/1ps

module ecc_ram_checker #(
    parameter int DEPTH = 64
) (
    input  logic              clk,
    input  logic              arst_n,
    input  ecc_pkg::axil_aw_t aw,
    input  ecc_pkg::axil_w_t  w,
    input  logic              awready,
    input  logic              wready,
    input  ecc_pkg::axil_b_t  b,
    input  logic              bready,
    input  ecc_pkg::axil_ar_t ar,
    input  logic              arready,
    input  ecc_pkg::axil_r_t  r,
    input  logic              rready,
    output int                errors,
    output int                b_done,
    output int                r_done
);
    import ecc_pkg::*;

    localparam int IDX_W = $clog2(DEPTH);

    data_t     orig [DEPTH]; // data as the master wrote it.
    codeword_t inj  [DEPTH]; // flips that went in with it.
    logic      bypass;
    codeword_t flip;
    count_t    count;
    resp_t     exp_bresp;
    word_t     exp_rdata;
    resp_t     exp_rresp;
    logic      b_pend;
    logic      b_seen;
    logic      r_pend;
    logic      r_seen;
    int        cycle = 0;
    int        wr_cycle;
    int        rd_cycle;

    initial begin
        errors = 0;
        b_done = 0;
        r_done = 0;
        for (int i = 0; i < DEPTH; i++) begin
            orig[i] = '0;
            inj[i]  = '0;
        end
    end

    task automatic flag_error(input string msg);
        $display("** Error @ %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic apply_write(input addr_t a, input word_t d);
        int idx;
        idx       = a[IDX_W+1:2];
        exp_bresp = RESP_OKAY;
        if (!a[REG_SPACE_BIT]) begin
            orig[idx] = d[$bits(data_t)-1:0];
            inj[idx]  = flip;
            flip      = '0; // spent on this write.
        end else if (a[REG_SPACE_BIT-1:0] == CTRL_OFFSET) begin
            bypass = d[0];
        end else if (a[REG_SPACE_BIT-1:0] == FLIP_OFFSET) begin
            flip = d[$bits(codeword_t)-1:0];
        end else begin
            exp_bresp = RESP_SLVERR;
        end
    endtask

    // the outcome follows from how many codeword bits were flipped.
    task automatic predict_read(input addr_t a);
        int        idx;
        int        n;
        codeword_t cw;
        idx       = a[IDX_W+1:2];
        cw.data   = orig[idx];
        cw.parity = ecc_check_bits(orig[idx]);
        cw        = cw ^ inj[idx];
        n         = $countones(inj[idx]);
        exp_rresp = RESP_OKAY;
        if (a[REG_SPACE_BIT]) begin
            case (a[REG_SPACE_BIT-1:0])
                CTRL_OFFSET:  exp_rdata = word_t'(bypass);
                FLIP_OFFSET:  exp_rdata = word_t'(flip);
                COUNT_OFFSET: exp_rdata = word_t'(count);
                default: begin
                    exp_rdata = '0;
                    exp_rresp = RESP_SLVERR;
                end
            endcase
        end else if (bypass || n == 0) begin
            exp_rdata = {8'b0, cw};
        end else if (n == 1) begin
            exp_rdata = {6'b0, 2'b01, cw.parity, orig[idx]}; // data restored.
            if (|inj[idx].data && count != '1) count++;
        end else begin
            exp_rdata = {6'b0, 2'b10, cw}; // raw.
            exp_rresp = RESP_SLVERR;
        end
    endtask

    // sampled mid cycle, where every signal is settled.
    always @(negedge clk) begin
        cycle++;
        if (!arst_n) begin
            bypass = 1'b0;
            flip   = '0;
            count  = '0;
            b_pend = 1'b0;
            b_seen = 1'b0;
            r_pend = 1'b0;
            r_seen = 1'b0;
        end else begin
            // readies are low exactly while a transfer is outstanding.
            if (awready !== !b_pend || wready !== !b_pend)
                flag_error($sformatf("awready %b wready %b, expected %b",
                                     awready, wready, !b_pend));
            if (arready !== !r_pend)
                flag_error($sformatf("arready %b, expected %b", arready, !r_pend));

            if (aw.awvalid && w.wvalid && awready && wready) begin
                apply_write(aw.awaddr, w.wdata);
                b_pend   = 1'b1;
                b_seen   = 1'b0;
                wr_cycle = cycle;
            end
            if (b.bvalid) begin
                if (!b_pend) begin
                    flag_error("write response without a write");
                end else if (!b_seen) begin
                    b_seen = 1'b1;
                    if (cycle != wr_cycle + 1)
                        flag_error($sformatf("bvalid %0d cycles after handshake, expected 1",
                                             cycle - wr_cycle));
                    if (b.bresp != exp_bresp)
                        flag_error($sformatf("bresp %0h, expected %0h", b.bresp, exp_bresp));
                end
                if (bready && b_pend) begin
                    b_pend = 1'b0;
                    b_done++;
                end
            end else if (b_pend && b_seen) begin
                flag_error("write response dropped before bready");
            end

            if (ar.arvalid && arready) begin
                predict_read(ar.araddr);
                r_pend   = 1'b1;
                r_seen   = 1'b0;
                rd_cycle = cycle;
            end
            if (r.rvalid) begin
                if (!r_pend) begin
                    flag_error("read response without a read");
                end else if (!r_seen) begin
                    r_seen = 1'b1;
                    if (cycle != rd_cycle + 3) // store read sits between the two stages.
                        flag_error($sformatf("rvalid %0d cycles after handshake, expected 3",
                                             cycle - rd_cycle));
                    if (r.rdata != exp_rdata || r.rresp != exp_rresp)
                        flag_error($sformatf("rdata %h rresp %0h, expected %h rresp %0h",
                                             r.rdata, r.rresp, exp_rdata, exp_rresp));
                end
                if (rready && r_pend) begin
                    r_pend = 1'b0;
                    r_done++;
                end
            end else if (r_pend && r_seen) begin
                flag_error("read response dropped before rready");
            end
        end
    end

endmodule

/* tb/tb_ecc_ram.sv */
`timescale 1ns/1ps

module tb_ecc_ram;
    import ecc_pkg::*;

    localparam int DEPTH        = 64;
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;
    localparam int N_OPS        = 300;
    localparam int DRIVE_DELAY  = 2;

    logic     clk;
    logic     arst_n;
    axil_aw_t aw;
    axil_w_t  w;
    axil_ar_t ar;
    axil_b_t  b;
    axil_r_t  r;
    logic     awready;
    logic     wready;
    logic     arready;
    logic     bready;
    logic     rready;
    int       seed     = 13;
    int       n_writes = 0;
    int       n_reads  = 0;
    int       errors;
    int       b_done;
    int       r_done;

    ecc_ram_top #(.DEPTH(DEPTH)) dut (
        .clk     (clk),
        .arst_n  (arst_n),
        .aw      (aw),
        .w       (w),
        .awready (awready),
        .wready  (wready),
        .b       (b),
        .bready  (bready),
        .ar      (ar),
        .arready (arready),
        .r       (r),
        .rready  (rready)
    );

    ecc_ram_checker #(.DEPTH(DEPTH)) u_checker (
        .clk     (clk),
        .arst_n  (arst_n),
        .aw      (aw),
        .w       (w),
        .awready (awready),
        .wready  (wready),
        .b       (b),
        .bready  (bready),
        .ar      (ar),
        .arready (arready),
        .r       (r),
        .rready  (rready),
        .errors  (errors),
        .b_done  (b_done),
        .r_done  (r_done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus driver.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // ready stays low a few cycles once the response shows up.
    task automatic take_response(input bit is_read);
        int stall;
        stall = $unsigned($random(seed)) % 4;
        while (!(is_read ? r.rvalid : b.bvalid)) next_cycle();
        repeat (stall) next_cycle();
        if (is_read) rready = 1'b1;
        else         bready = 1'b1;
        next_cycle();
        rready = 1'b0;
        bready = 1'b0;
    endtask

    task automatic write_op(input addr_t addr, input word_t data);
        logic accepted;
        aw = '{awaddr: addr, awvalid: 1'b1};
        w  = '{wdata: data, wstrb: 4'hf, wvalid: 1'b1};
        do begin
            accepted = awready && wready; // stable until the next edge.
            next_cycle();
        end while (!accepted);
        aw.awvalid = 1'b0;
        w.wvalid   = 1'b0;
        n_writes++;
        take_response(1'b0);
    endtask

    task automatic read_op(input addr_t addr);
        logic accepted;
        ar = '{araddr: addr, arvalid: 1'b1};
        do begin
            accepted = arready;
            next_cycle();
        end while (!accepted);
        ar.arvalid = 1'b0;
        n_reads++;
        take_response(1'b1);
    endtask

    // mostly a small window of words, so injected errors get read back.
    function automatic addr_t mem_addr();
        int wide;
        int idx;
        wide = $unsigned($random(seed)) % 4;
        idx  = $unsigned($random(seed)) % ((wide == 0) ? DEPTH : 8);
        return addr_t'(idx * 4);
    endfunction

    function automatic addr_t reg_addr();
        int pick;
        pick = $unsigned($random(seed)) % 4;
        case (pick)
            0:       return {1'b1, CTRL_OFFSET};
            1:       return {1'b1, FLIP_OFFSET};
            2:       return {1'b1, COUNT_OFFSET};
            default: return {1'b1, 10'($unsigned($random(seed)) % 1000 + 3), 2'b00};
        endcase
    endfunction

    task automatic reg_write();
        int    pick;
        int    n_flips;
        word_t mask;
        pick    = $unsigned($random(seed)) % 8;
        n_flips = $unsigned($random(seed)) % 3;
        mask    = '0;
        for (int k = 0; k < n_flips; k++) begin
            mask[$unsigned($random(seed)) % $bits(codeword_t)] = 1'b1;
        end
        if (pick < 4)       write_op({1'b1, FLIP_OFFSET}, mask); // zero, one or two flips.
        else if (pick < 6)  write_op({1'b1, CTRL_OFFSET}, ($unsigned($random(seed)) % 4) == 0);
        else if (pick == 6) write_op({1'b1, COUNT_OFFSET}, $random(seed));
        else                write_op({1'b1, 12'hff0}, $random(seed));
    endtask

    initial begin
        int op;
        aw     = '0;
        w      = '0;
        ar     = '0;
        bready = 1'b0;
        rready = 1'b0;
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        arst_n = 1'b1;
        next_cycle();
        for (int i = 0; i < N_OPS; i++) begin
            op = $unsigned($random(seed)) % 10;
            if (op < 4)       write_op(mem_addr(), $random(seed));
            else if (op < 7)  read_op(mem_addr());
            else if (op == 7) read_op(reg_addr());
            else              reg_write();
        end
        repeat (4) next_cycle();
        $display("writes %0d, reads %0d, b responses %0d, r responses %0d, errors %0d",
                 n_writes, n_reads, b_done, r_done, errors);
        if (errors == 0 && b_done == n_writes && r_done == n_reads) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // watchdog.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        #((N_OPS * 10 + RESET_CYCLES) * CLK_PERIOD);
        $display("timeout: the bus operations did not finish in the allowed time");
        $display("Simulation FAILED");
        $finish;
    end

endmodule

/* build.f */
source/ecc_pkg.sv
source/ecc_secded_18.sv
source/ecc_axil_write.sv
source/ecc_axil_read.sv
source/ecc_store.sv
source/ecc_ram_top.sv
tb/ecc_ram_checker.sv
tb/tb_ecc_ram.sv

/* Bender.yml */
package:
  name: ecc_ram

sources:
  - files:
      - source/ecc_pkg.sv
      - source/ecc_secded_18.sv
      - source/ecc_axil_write.sv
      - source/ecc_axil_read.sv
      - source/ecc_store.sv
      - source/ecc_ram_top.sv
  - target: test
    files:
      - tb/ecc_ram_checker.sv
      - tb/tb_ecc_ram.sv
